//--- silent_cfg.svh
// build configuration for the silencer subsystem
// value widths, channel count and the wishbone register map
`ifndef SILENT_CFG_SVH
`define SILENT_CFG_SVH

// duty, phase, cycle and step width
`define SIL_WIDTH 13
`define SIL_DEPTH 8
`define SIL_CH_BITS 4

`define SIL_ADDR_BITS 8
`define SIL_WB_BITS 32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map, per-channel bases take the channel in the low nibble
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SIL_REG_CTRL 8'h00
`define SIL_REG_STEP 8'h01
`define SIL_REG_STATUS 8'h02
`define SIL_BASE_CYCLE 8'h10
`define SIL_BASE_DUTY 8'h20
`define SIL_BASE_PHASE 8'h30
`define SIL_BASE_RD_DUTY 8'h40
`define SIL_BASE_RD_PHASE 8'h50

`endif

//--- silent_pkg.sv
// shared types for the silencer subsystem
// wishbone request, channel records, register select and core states
`include "silent_cfg.svh"

package silent_pkg;

  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`SIL_ADDR_BITS-1:0] adr;
    logic [`SIL_WB_BITS-1:0]   dat_w;
  } wb_req_t;

  // one channel's drive period and targets
  typedef struct packed {
    logic [`SIL_CH_BITS-1:0] idx;
    logic [`SIL_WIDTH-1:0]   cycle;
    logic [`SIL_WIDTH-1:0]   duty;
    logic [`SIL_WIDTH-1:0]   phase;
  } chan_cfg_t;

  typedef struct packed {
    logic [`SIL_WIDTH-1:0] duty;
    logic [`SIL_WIDTH-1:0] phase;
  } chan_cur_t;

  typedef struct packed {
    logic [`SIL_CH_BITS-1:0] idx;
    logic [`SIL_WIDTH-1:0]   duty;
    logic [`SIL_WIDTH-1:0]   phase;
  } chan_out_t;

  typedef enum logic [3:0] {
    SEL_CTRL,
    SEL_STEP,
    SEL_STATUS,
    SEL_CYCLE,
    SEL_DUTY,
    SEL_PHASE,
    SEL_RD_DUTY,
    SEL_RD_PHASE,
    SEL_NONE
  } reg_sel_e;

  typedef enum logic {
    CORE_IDLE,
    CORE_RUN
  } core_state_e;

endpackage

//--- wb_decode.sv
// wishbone classic slave for the silencer
// register decode, config memories, frame start and status readback
`timescale 1ns/10ps
`include "silent_cfg.svh"

module wb_decode (
  input  logic                    CLK,
  input  logic                    arst_n,
  input  silent_pkg::wb_req_t     wb_in,
  output logic [`SIL_WB_BITS-1:0] dat_r,
  output logic                    ack,
  output logic                    start,
  output logic [`SIL_WIDTH-1:0]   step,
  input  logic                    busy,
  input  logic [`SIL_CH_BITS-1:0] cfg_idx,
  output silent_pkg::chan_cfg_t   cfg,
  output logic [`SIL_CH_BITS-1:0] rd_idx,
  input  silent_pkg::chan_cur_t   rd_cur
);
  import silent_pkg::*;

  localparam int IW = (`SIL_DEPTH > 1) ? $clog2(`SIL_DEPTH) : 1;
  localparam int BW = `SIL_ADDR_BITS - `SIL_CH_BITS;
  localparam logic [BW-1:0] BlkCycle   = BW'(`SIL_BASE_CYCLE >> `SIL_CH_BITS);
  localparam logic [BW-1:0] BlkDuty    = BW'(`SIL_BASE_DUTY >> `SIL_CH_BITS);
  localparam logic [BW-1:0] BlkPhase   = BW'(`SIL_BASE_PHASE >> `SIL_CH_BITS);
  localparam logic [BW-1:0] BlkRdDuty  = BW'(`SIL_BASE_RD_DUTY >> `SIL_CH_BITS);
  localparam logic [BW-1:0] BlkRdPhase = BW'(`SIL_BASE_RD_PHASE >> `SIL_CH_BITS);

  reg_sel_e              sel;
  logic                  req;
  logic                  wr_en;
  logic [IW-1:0]         ch;
  logic                  busy_q;
  logic [7:0]            frame_cnt;
  logic [`SIL_WIDTH-1:0] cycle_mem[`SIL_DEPTH];
  logic [`SIL_WIDTH-1:0] duty_mem [`SIL_DEPTH];
  logic [`SIL_WIDTH-1:0] phase_mem[`SIL_DEPTH];

  function automatic reg_sel_e decode_adr(input logic [`SIL_ADDR_BITS-1:0] adr);
    logic [BW-1:0] blk;
    logic          in_range;
    blk      = adr[`SIL_ADDR_BITS-1:`SIL_CH_BITS];
    in_range = 32'(adr[`SIL_CH_BITS-1:0]) < `SIL_DEPTH;
    decode_adr = SEL_NONE;
    if (adr == `SIL_REG_CTRL) begin
      decode_adr = SEL_CTRL;
    end else if (adr == `SIL_REG_STEP) begin
      decode_adr = SEL_STEP;
    end else if (adr == `SIL_REG_STATUS) begin
      decode_adr = SEL_STATUS;
    end else if (in_range) begin
      case (blk)
        BlkCycle:   decode_adr = SEL_CYCLE;
        BlkDuty:    decode_adr = SEL_DUTY;
        BlkPhase:   decode_adr = SEL_PHASE;
        BlkRdDuty:  decode_adr = SEL_RD_DUTY;
        BlkRdPhase: decode_adr = SEL_RD_PHASE;
        default:    decode_adr = SEL_NONE;
      endcase
    end
  endfunction

  // the master holds the request through the ack cycle, so decode stays valid
  assign sel    = decode_adr(wb_in.adr);
  assign req    = wb_in.cyc && wb_in.stb;
  assign wr_en  = req && wb_in.we && !ack;
  assign ch     = wb_in.adr[IW-1:0];
  assign rd_idx = wb_in.adr[`SIL_CH_BITS-1:0];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ack       <= 1'b0;
      start     <= 1'b0;
      step      <= '0;
      busy_q    <= 1'b0;
      frame_cnt <= '0;
    end else begin
      ack    <= req && !ack;
      // a frame request during a running frame is dropped
      start  <= ack && req && wb_in.we && (sel == SEL_CTRL) && wb_in.dat_w[0] && !busy;
      busy_q <= busy;
      if (busy_q && !busy) begin
        frame_cnt <= frame_cnt + 1'b1;
      end
      if (wr_en && (sel == SEL_STEP)) begin
        step <= wb_in.dat_w[`SIL_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      case (sel)
        SEL_CYCLE: cycle_mem[ch] <= wb_in.dat_w[`SIL_WIDTH-1:0];
        SEL_DUTY:  duty_mem[ch]  <= wb_in.dat_w[`SIL_WIDTH-1:0];
        SEL_PHASE: phase_mem[ch] <= wb_in.dat_w[`SIL_WIDTH-1:0];
        default: begin
        end
      endcase
    end
    cfg.idx   <= cfg_idx;
    cfg.cycle <= cycle_mem[cfg_idx[IW-1:0]];
    cfg.duty  <= duty_mem[cfg_idx[IW-1:0]];
    cfg.phase <= phase_mem[cfg_idx[IW-1:0]];
  end

  // current values arrive from the store one cycle after rd_idx, in the ack cycle
  always_comb begin
    case (sel)
      SEL_STEP:     dat_r = `SIL_WB_BITS'(step);
      SEL_STATUS:   dat_r = `SIL_WB_BITS'({frame_cnt, 7'd0, busy});
      SEL_CYCLE:    dat_r = `SIL_WB_BITS'(cycle_mem[ch]);
      SEL_DUTY:     dat_r = `SIL_WB_BITS'(duty_mem[ch]);
      SEL_PHASE:    dat_r = `SIL_WB_BITS'(phase_mem[ch]);
      SEL_RD_DUTY:  dat_r = `SIL_WB_BITS'(rd_cur.duty);
      SEL_RD_PHASE: dat_r = `SIL_WB_BITS'(rd_cur.phase);
      default:      dat_r = '0;
    endcase
  end

  a_ack_follows_cyc: assert property (
    @(posedge CLK) disable iff (!arst_n) ack |-> $past(wb_in.cyc)
  );

endmodule

//--- silencer_core.sv
// silencer execute stage
// four-stage pipeline slewing each channel's duty and phase toward target
`timescale 1ns/10ps
`include "silent_cfg.svh"

module silencer_core (
  input  logic                    CLK,
  input  logic                    arst_n,
  input  logic                    start,
  input  logic [`SIL_WIDTH-1:0]   step,
  output logic [`SIL_CH_BITS-1:0] cfg_idx,
  input  silent_pkg::chan_cfg_t   cfg,
  output logic [`SIL_CH_BITS-1:0] cur_idx,
  input  silent_pkg::chan_cur_t   cur,
  output logic                    res_valid,
  output silent_pkg::chan_out_t   res,
  output logic                    busy
);
  import silent_pkg::*;

  // two guard bits hold the sign and the overflow of a difference
  localparam int DW = `SIL_WIDTH + 2;
  localparam logic [`SIL_CH_BITS-1:0] LastCh = `SIL_CH_BITS'(`SIL_DEPTH - 1);

  typedef logic signed [DW-1:0] sval_t;

  core_state_e             state;
  logic [`SIL_CH_BITS-1:0] issue_cnt;
  logic                    issue;
  sval_t                   step_q;

  logic                    v0, v1, v2, v3;
  logic                    tail_q;
  logic [`SIL_CH_BITS-1:0] idx1, idx2, idx3;
  sval_t                   cyc1, cyc2, cyc3;
  sval_t                   dd1, dp1, cd1, cp1;
  sval_t                   dd2, dp2, cd2, cp2;
  sval_t                   nd3, np3;
  sval_t                   half1;
  sval_t                   fold3;

  function automatic sval_t widen(input logic [`SIL_WIDTH-1:0] v);
    widen = sval_t'({2'b00, v});
  endfunction

  function automatic sval_t clamp(input sval_t d, input sval_t lim);
    if (d > lim) begin
      clamp = lim;
    end else if (d < -lim) begin
      clamp = -lim;
    end else begin
      clamp = d;
    end
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // issue, channel 0 goes out in the start cycle itself
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign issue   = (state == CORE_RUN) || (start && (state == CORE_IDLE));
  assign cur_idx = (state == CORE_RUN) ? issue_cnt : '0;
  assign cfg_idx = cur_idx;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state     <= CORE_IDLE;
      issue_cnt <= '0;
    end else begin
      case (state)
        CORE_IDLE: begin
          if (start) begin
            issue_cnt <= `SIL_CH_BITS'(1);
            state     <= (`SIL_DEPTH > 1) ? CORE_RUN : CORE_IDLE;
          end
        end
        CORE_RUN: begin
          issue_cnt <= issue_cnt + 1'b1;
          if (issue_cnt == LastCh) begin
            state <= CORE_IDLE;
          end
        end
        default: state <= CORE_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      v0        <= 1'b0;
      v1        <= 1'b0;
      v2        <= 1'b0;
      v3        <= 1'b0;
      res_valid <= 1'b0;
      tail_q    <= 1'b0;
    end else begin
      v0        <= issue;
      v1        <= v0;
      v2        <= v1;
      v3        <= v2;
      res_valid <= v3;
      tail_q    <= res_valid;
    end
  end

  // stays high until the store has forwarded the last result
  assign busy = (state == CORE_RUN) || v0 || v1 || v2 || v3 || res_valid || tail_q;

  assign half1 = cyc1 >>> 1;

  always_comb begin
    if (np3 >= cyc3) begin
      fold3 = np3 - cyc3;
    end else if (np3 < 0) begin
      fold3 = np3 + cyc3;
    end else begin
      fold3 = np3;
    end
  end

  always_ff @(posedge CLK) begin
    if (start && (state == CORE_IDLE)) begin
      step_q <= widen(step);
    end

    // stage 1 target minus current
    idx1 <= cfg.idx;
    cyc1 <= widen(cfg.cycle);
    dd1  <= widen(cfg.duty) - widen(cur.duty);
    dp1  <= widen(cfg.phase) - widen(cur.phase);
    cd1  <= widen(cur.duty);
    cp1  <= widen(cur.phase);

    // stage 2 take the short way around the period
    idx2 <= idx1;
    cyc2 <= cyc1;
    dd2  <= dd1;
    cd2  <= cd1;
    cp2  <= cp1;
    if (dp1 > half1) begin
      dp2 <= dp1 - cyc1;
    end else if (dp1 < -half1) begin
      dp2 <= dp1 + cyc1;
    end else begin
      dp2 <= dp1;
    end

    // stage 3 limited step
    idx3 <= idx2;
    cyc3 <= cyc2;
    nd3  <= cd2 + clamp(dd2, step_q);
    np3  <= cp2 + clamp(dp2, step_q);

    // stage 4 phase back into 0 to cycle-1
    res.idx   <= idx3;
    res.duty  <= nd3[`SIL_WIDTH-1:0];
    res.phase <= fold3[`SIL_WIDTH-1:0];
  end

  // a result only follows an issue five cycles earlier and carries that channel
  a_no_stray_result: assert property (
    @(posedge CLK) disable iff (!arst_n)
    res_valid |-> ($past(issue, 5) && (res.idx == $past(cur_idx, 5)))
  );

endmodule

//--- silenced_store.sv
// silencer result stage
// current duty and phase per channel, write-back and output stream
`timescale 1ns/10ps
`include "silent_cfg.svh"

module silenced_store (
  input  logic                    CLK,
  input  logic                    arst_n,
  input  logic [`SIL_CH_BITS-1:0] cur_idx,
  output silent_pkg::chan_cur_t   cur,
  input  logic                    res_valid,
  input  silent_pkg::chan_out_t   res,
  input  logic [`SIL_CH_BITS-1:0] rd_idx,
  output silent_pkg::chan_cur_t   rd_cur,
  output logic                    out_valid,
  output silent_pkg::chan_out_t   out_data
);
  import silent_pkg::*;

  localparam int IW = (`SIL_DEPTH > 1) ? $clog2(`SIL_DEPTH) : 1;

  logic [`SIL_WIDTH-1:0] cur_duty [`SIL_DEPTH];
  logic [`SIL_WIDTH-1:0] cur_phase[`SIL_DEPTH];

  // all channels start from zero duty and phase
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `SIL_DEPTH; i++) begin
        cur_duty[i]  <= '0;
        cur_phase[i] <= '0;
      end
      out_valid <= 1'b0;
    end else begin
      out_valid <= res_valid;
      if (res_valid) begin
        cur_duty[res.idx[IW-1:0]]  <= res.duty;
        cur_phase[res.idx[IW-1:0]] <= res.phase;
      end
    end
  end

  // core port and wishbone port both answer one cycle after the index
  always_ff @(posedge CLK) begin
    cur.duty     <= cur_duty[cur_idx[IW-1:0]];
    cur.phase    <= cur_phase[cur_idx[IW-1:0]];
    rd_cur.duty  <= cur_duty[rd_idx[IW-1:0]];
    rd_cur.phase <= cur_phase[rd_idx[IW-1:0]];
    out_data     <= res;
  end

  a_res_idx_in_range: assert property (
    @(posedge CLK) disable iff (!arst_n) res_valid |-> (32'(res.idx) < `SIL_DEPTH)
  );

endmodule

//--- silent_top.sv
// silencer subsystem top level
// wishbone decode, silencer pipeline and current-value store
`timescale 1ns/10ps
`include "silent_cfg.svh"

module silent_top (
  input  logic                    CLK,
  input  logic                    arst_n,
  input  silent_pkg::wb_req_t     wb_in,
  output logic [`SIL_WB_BITS-1:0] dat_r,
  output logic                    ack,
  output logic                    out_valid,
  output silent_pkg::chan_out_t   out_data
);
  import silent_pkg::*;

  logic                    start;
  logic                    busy;
  logic [`SIL_WIDTH-1:0]   step;
  logic [`SIL_CH_BITS-1:0] cfg_idx;
  logic [`SIL_CH_BITS-1:0] cur_idx;
  logic [`SIL_CH_BITS-1:0] rd_idx;
  chan_cfg_t               cfg;
  chan_cur_t               cur;
  chan_cur_t               rd_cur;
  logic                    res_valid;
  chan_out_t               res;

  wb_decode u_decode (
    .CLK    (CLK),
    .arst_n (arst_n),
    .wb_in  (wb_in),
    .dat_r  (dat_r),
    .ack    (ack),
    .start  (start),
    .step   (step),
    .busy   (busy),
    .cfg_idx(cfg_idx),
    .cfg    (cfg),
    .rd_idx (rd_idx),
    .rd_cur (rd_cur)
  );

  silencer_core u_core (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .start    (start),
    .step     (step),
    .cfg_idx  (cfg_idx),
    .cfg      (cfg),
    .cur_idx  (cur_idx),
    .cur      (cur),
    .res_valid(res_valid),
    .res      (res),
    .busy     (busy)
  );

  silenced_store u_store (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .cur_idx  (cur_idx),
    .cur      (cur),
    .res_valid(res_valid),
    .res      (res),
    .rd_idx   (rd_idx),
    .rd_cur   (rd_cur),
    .out_valid(out_valid),
    .out_data (out_data)
  );

endmodule

//--- tb_silent.sv
// testbench for the silencer subsystem
// pattern file stimulus, channel reference model and output stream checks
`timescale 1ns/10ps
`include "silent_cfg.svh"

module tb_silent;
  import silent_pkg::*;

  logic                    CLK;
  logic                    arst_n;
  wb_req_t                 wb_in;
  logic [`SIL_WB_BITS-1:0] dat_r;
  logic                    ack;
  logic                    out_valid;
  chan_out_t               out_data;

  byte         ops[$];
  logic [7:0]  addrs[$];
  logic [31:0] datas[$];
  int          limit = 200;
  int          cycles = 0;
  logic [31:0] lfsr_state = 32'h1e68;

  // model of the per-channel registers and current values
  int        m_cycle[`SIL_DEPTH];
  int        m_tduty[`SIL_DEPTH];
  int        m_tphase[`SIL_DEPTH];
  int        m_duty[`SIL_DEPTH];
  int        m_phase[`SIL_DEPTH];
  int        m_step = 0;
  chan_out_t expect_q[`SIL_DEPTH];

  silent_top UUT (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .wb_in    (wb_in),
    .dat_r    (dat_r),
    .ack      (ack),
    .out_valid(out_valid),
    .out_data (out_data)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      abort_run("the run timed out before the pattern file was finished");
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int clamp_to_step(input int d);
    if (d > m_step) begin
      clamp_to_step = m_step;
    end else if (d < -m_step) begin
      clamp_to_step = -m_step;
    end else begin
      clamp_to_step = d;
    end
  endfunction

  function automatic void model_write(input logic [7:0] adr, input logic [31:0] d);
    int ch;
    int v;
    ch = int'(adr[`SIL_CH_BITS-1:0]);
    v  = int'(d[`SIL_WIDTH-1:0]);
    if (adr == `SIL_REG_STEP) begin
      m_step = v;
    end else if (ch < `SIL_DEPTH) begin
      case ({adr[7:4], 4'h0})
        `SIL_BASE_CYCLE: m_cycle[ch] = v;
        `SIL_BASE_DUTY:  m_tduty[ch] = v;
        `SIL_BASE_PHASE: m_tphase[ch] = v;
        default: begin
        end
      endcase
    end
  endfunction

  // one frame of slew, leaves the expected stream in expect_q
  function automatic void model_frame();
    int dd;
    int dp;
    int np;
    for (int i = 0; i < `SIL_DEPTH; i++) begin
      dd = m_tduty[i] - m_duty[i];
      dp = m_tphase[i] - m_phase[i];
      if (dp > m_cycle[i] / 2) begin
        dp = dp - m_cycle[i];
      end else if (dp < -(m_cycle[i] / 2)) begin
        dp = dp + m_cycle[i];
      end
      np = m_phase[i] + clamp_to_step(dp);
      if (np >= m_cycle[i]) begin
        np = np - m_cycle[i];
      end else if (np < 0) begin
        np = np + m_cycle[i];
      end
      m_duty[i]  = m_duty[i] + clamp_to_step(dd);
      m_phase[i] = np;
      expect_q[i].idx   = `SIL_CH_BITS'(i);
      expect_q[i].duty  = `SIL_WIDTH'(m_duty[i]);
      expect_q[i].phase = `SIL_WIDTH'(m_phase[i]);
    end
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_out(input chan_out_t got, input chan_out_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error out_data idx/duty/phase got %h/%h/%h expected %h/%h/%h",
                          got.idx, got.duty, got.phase, exp.idx, exp.duty, exp.phase));
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_status(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("error status busy %h frames %h expected busy %h frames %h",
                          got[0], got[15:8], exp[0], exp[15:8]));
    end
  endtask

  task automatic check_ack(input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("error ack got %h expected %h", got, exp));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // wishbone master
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic idle_gap();
    int gap;
    gap = 0;
    repeat (2) begin
      lfsr_state = lfsr_next(lfsr_state);
      gap = gap * 2 + int'(lfsr_state[0]);
    end
    repeat (gap) @(negedge CLK);
  endtask

  task automatic bus_access(input logic we, input logic [`SIL_ADDR_BITS-1:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    idle_gap();
    wb_in = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdat};
    // ack comes exactly one cycle after the request and lasts one cycle
    @(negedge CLK);
    check_ack(ack, 1'b1);
    rdat = dat_r;
    // the request stays up through the ack cycle
    @(negedge CLK);
    check_ack(ack, 1'b0);
    wb_in = '0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] d);
    logic [31:0] ignored;
    bus_access(1'b1, adr, d, ignored);
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] d);
    bus_access(1'b0, adr, 32'h0, d);
  endtask

  task automatic check_readback();
    logic [31:0] got;
    for (int i = 0; i < `SIL_DEPTH; i++) begin
      wb_read(8'(`SIL_BASE_RD_DUTY + i), got);
      check_word($sformatf("rd_duty[%0d]", i), got, 32'(m_duty[i]));
      wb_read(8'(`SIL_BASE_RD_PHASE + i), got);
      check_word($sformatf("rd_phase[%0d]", i), got, 32'(m_phase[i]));
    end
  endtask

  task automatic run_frame();
    logic [31:0] stat;
    model_frame();
    wb_write(`SIL_REG_CTRL, 32'h1);
    fork
      begin
        // a second start once issue is over but results still drain must be dropped
        while (!out_valid) @(negedge CLK);
        @(negedge CLK);
        wb_write(`SIL_REG_CTRL, 32'h1);
      end
      begin
        while (!out_valid) @(negedge CLK);
        for (int i = 0; i < `SIL_DEPTH; i++) begin
          if (!out_valid) begin
            abort_run("the output stream stopped before the last channel");
          end
          check_out(out_data, expect_q[i]);
          @(negedge CLK);
        end
        if (out_valid) begin
          abort_run("the output stream carried more items than there are channels");
        end
      end
    join
    stat = 32'h1;
    while (stat[0]) wb_read(`SIL_REG_STATUS, stat);
    check_readback();
  endtask

  task automatic load_patterns();
    int          fd;
    string       line;
    logic [31:0] a;
    logic [31:0] d;
    fd = $fopen("silent_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open silent_patterns.txt for reading");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      a = '0;
      d = '0;
      if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
        if (line.len() > 2) begin
          void'($sscanf(line.substr(2, line.len() - 1), "%h %h", a, d));
        end
        ops.push_back(byte'(line.getc(0)));
        addrs.push_back(a[7:0]);
        datas.push_back(d);
      end
    end
    $fclose(fd);
    limit = ops.size() * 40 + 200;
  endtask

  initial begin
    logic [31:0] got;
    arst_n = 1'b0;
    wb_in  = '0;
    load_patterns();
    repeat (16) @(negedge CLK);
    arst_n = 1'b1;
    // every channel starts with a zero period and zero targets
    for (int i = 0; i < `SIL_DEPTH; i++) begin
      wb_write(8'(`SIL_BASE_CYCLE + i), 32'h0);
      wb_write(8'(`SIL_BASE_DUTY + i), 32'h0);
      wb_write(8'(`SIL_BASE_PHASE + i), 32'h0);
    end
    check_readback();
    foreach (ops[i]) begin
      case (ops[i])
        "W": begin
          wb_write(addrs[i], datas[i]);
          model_write(addrs[i], datas[i]);
        end
        "R": begin
          wb_read(addrs[i], got);
          if (addrs[i] == `SIL_REG_STATUS) begin
            check_status(got, datas[i]);
          end else begin
            check_word($sformatf("dat_r at %h", addrs[i]), got, datas[i]);
          end
        end
        "F": run_frame();
        default: abort_run("unknown command letter in silent_patterns.txt");
      endcase
    end
    $display("Regression passed");
    $finish;
  end

endmodule

//--- silent_patterns.txt
# op addr data in hex: W writes data to addr, R reads addr and expects data
# F starts a frame and checks the stream; R 02 holds the frame count in bits 15:8
R 02 00000000
W 01 00000008
W 10 000003e8
W 11 00000064
W 20 00000014
W 31 0000000a
W 27 00000100
R 11 00000064
R 01 00000008
F
F
R 02 00000200
R 40 00000010
R 51 0000000a
W 31 0000005f
F
R 51 00000002
F
R 51 0000005f
R 40 00000014
R 47 00000020
R 02 00000400

//--- tb.f
+incdir+.
silent_pkg.sv
wb_decode.sv
silencer_core.sv
silenced_store.sv
silent_top.sv
tb_silent.sv

//--- run_sim.sh
#!/bin/sh
# build the silencer testbench with Verilator, then run it
verilator --binary --timing --assert -f tb.f --top-module tb_silent -o sim_tb_silent \
  && ./obj_dir/sim_tb_silent \
  || exit 1
